// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - rename_pkg.sv
  - dispatch_unit.sv
  - map_table.sv
  - free_list.sv
  - issue_queue.sv
  - phys_regfile.sv
  - alu_unit.sv
  - reorder_buffer.sv
  - rename_core.sv
  - target: test
    files:
      - rename_core_checker.sv
      - rename_core_tb.sv

// ==== alu_unit.sv ====
// single cycle integer alu
`default_nettype none

module alu_unit import rename_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  wire logic                         clock,
    input  wire logic                         rst_n,
    input  wire logic                         issue_valid,
    input  wire alu_op_t                      op,
    input  wire word_t                        imm,
    input  wire word_t                        src1_value,
    input  wire word_t                        src2_value,
    input  wire preg_t                        dest_preg,
    input  wire logic [$clog2(ROB_DEPTH)-1:0] rob_tag,
    output logic                              wb_valid,   // one cycle per result
    output preg_t                             wb_preg,
    output logic [$clog2(ROB_DEPTH)-1:0]      wb_tag,
    output word_t                             wb_value
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    word_t result;

    always_comb begin
        case (op)
            OP_ADD:  result = src1_value + src2_value;
            OP_SUB:  result = src1_value - src2_value;
            OP_AND:  result = src1_value & src2_value;
            OP_OR:   result = src1_value | src2_value;
            OP_XOR:  result = src1_value ^ src2_value;
            OP_ADDI: result = src1_value + imm;
            OP_SLL:  result = src1_value << src2_value[4:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) wb_valid <= 1'b0;
        else        wb_valid <= issue_valid;
    end

    // result register, tagged for regfile and rob
    always_ff @(posedge clock) begin
        if (issue_valid) begin
            wb_value <= result;
            wb_preg  <= dest_preg;
            wb_tag   <= TAG_W'(rob_tag);
        end
    end

endmodule

`default_nettype wire

// ==== dispatch_unit.sv ====
// dispatch stall and allocation
`default_nettype none

module dispatch_unit import rename_pkg::*; (
    // decoded instruction
    input  wire logic  inst_valid,
    input  wire areg_t inst_rd,
    // resource status
    input  wire logic  fl_empty,
    input  wire preg_t free_preg,     // free list head
    input  wire logic  rob_full,
    input  wire logic  iq_full,
    // allocation strobes
    output logic       stall,
    output logic       rename_en,
    output logic       pop,
    output logic       iq_push,
    output logic       rob_alloc,
    output logic       clear_ready,
    output preg_t      dest_preg
);

    logic rd_live;    // rd is not x0, needs a fresh physical reg
    logic accept;

    assign rd_live = (inst_rd != '0);

    // any structural hazard holds the instruction at the input
    assign stall  = rob_full | iq_full | (fl_empty & rd_live);
    assign accept = inst_valid & ~stall;

    // x0 writes take p0 and allocate no register
    assign dest_preg = rd_live ? free_preg : '0;

    assign rename_en   = accept & rd_live;
    assign pop         = accept & rd_live;
    assign clear_ready = accept & rd_live;   // new dest not ready until wb
    assign iq_push     = accept;
    assign rob_alloc   = accept;             // every instruction gets an entry

endmodule

`default_nettype wire

// ==== free_list.sv ====
// free physical register list
`default_nettype none

module free_list import rename_pkg::*; (
    input  wire logic  clock,
    input  wire logic  rst_n,
    input  wire logic  pop,          // dispatch takes the head
    input  wire logic  push,         // retire gives one back
    input  wire preg_t push_preg,
    output preg_t      free_preg,
    output logic       empty
);

    localparam int FL_DEPTH = NUM_PREG - NUM_AREG;
    localparam int PTR_W    = $clog2(FL_DEPTH);

    preg_t            list_q [FL_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                list_q[i] <= preg_t'(NUM_AREG + i);   // p32..p63
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (PTR_W + 1)'(FL_DEPTH);       // starts full
        end else begin
            if (push) begin
                list_q[tail_q] <= push_preg;
                tail_q         <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;        // none, or both
            endcase
        end
    end

    assign free_preg = list_q[head_q];
    assign empty     = (count_q == '0);

endmodule

`default_nettype wire

// ==== issue_queue.sv ====
// in-order issue queue
`default_nettype none

module issue_queue import rename_pkg::*; #(
    parameter int IQ_DEPTH  = 4,   // power of two
    parameter int ROB_DEPTH = 8
) (
    input  wire logic                         clock,
    input  wire logic                         rst_n,
    // push side, from rename
    input  wire logic                         push,
    input  wire alu_op_t                      op,
    input  wire word_t                        imm,
    input  wire preg_t                        src1_preg,
    input  wire preg_t                        src2_preg,
    input  wire preg_t                        dest_preg,
    input  wire logic [$clog2(ROB_DEPTH)-1:0] rob_tag,
    // ready bits of the head sources
    input  wire logic                         src1_ready,
    input  wire logic                         src2_ready,
    output logic                              full,
    // head, to regfile read ports and alu
    output logic                              issue_valid,
    output alu_op_t                           issue_op,
    output word_t                             issue_imm,
    output preg_t                             issue_src1,
    output preg_t                             issue_src2,
    output preg_t                             issue_dest,
    output logic [$clog2(ROB_DEPTH)-1:0]      issue_tag
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int PTR_W = $clog2(IQ_DEPTH);

    alu_op_t          op_q   [IQ_DEPTH];
    word_t            imm_q  [IQ_DEPTH];
    preg_t            src1_q [IQ_DEPTH];
    preg_t            src2_q [IQ_DEPTH];
    preg_t            dest_q [IQ_DEPTH];
    logic [TAG_W-1:0] tag_q  [IQ_DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;

    ////////////////////////////////////////////////
    // pointers
    ////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push)        tail_q <= tail_q + 1'b1;
            if (issue_valid) head_q <= head_q + 1'b1;
            case ({push, issue_valid})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // payload
    always_ff @(posedge clock) begin
        if (push) begin
            op_q[tail_q]   <= op;
            imm_q[tail_q]  <= imm;
            src1_q[tail_q] <= src1_preg;
            src2_q[tail_q] <= src2_preg;
            dest_q[tail_q] <= dest_preg;
            tag_q[tail_q]  <= rob_tag;
        end
    end

    assign full = (count_q == (PTR_W + 1)'(IQ_DEPTH));

    // only the head may go, so issue stays in program order
    assign issue_valid = (count_q != '0) & src1_ready & src2_ready;
    assign issue_op    = op_q[head_q];
    assign issue_imm   = imm_q[head_q];
    assign issue_src1  = src1_q[head_q];
    assign issue_src2  = src2_q[head_q];
    assign issue_dest  = dest_q[head_q];
    assign issue_tag   = tag_q[head_q];

endmodule

`default_nettype wire

// ==== map_table.sv ====
// speculative register map
`default_nettype none

module map_table import rename_pkg::*; (
    input  wire logic  clock,
    input  wire logic  rst_n,
    input  wire logic  rename_en,
    input  wire areg_t rd,
    input  wire areg_t rs1,
    input  wire areg_t rs2,
    input  wire preg_t new_preg,
    output preg_t      src1_preg,
    output preg_t      src2_preg,
    output preg_t      old_preg
);

    preg_t map_q [NUM_AREG];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AREG; i++) begin
                map_q[i] <= preg_t'(i);   // identity, xN -> pN
            end
        end else if (rename_en && rd != '0) begin
            map_q[rd] <= new_preg;       // x0 stays on p0
        end
    end

    // lookups see the map before this cycle's rename
    assign src1_preg = map_q[rs1];
    assign src2_preg = map_q[rs2];
    assign old_preg  = map_q[rd];       // released when this inst retires

endmodule

`default_nettype wire

// ==== phys_regfile.sv ====
// physical register file with ready bits
`default_nettype none

module phys_regfile import rename_pkg::*; (
    input  wire logic  clock,
    input  wire logic  rst_n,
    input  wire preg_t rd1_preg,
    input  wire preg_t rd2_preg,
    output word_t      rd1_value,
    output word_t      rd2_value,
    output logic       rd1_ready,
    output logic       rd2_ready,
    input  wire logic  clear_en,     // allocation at dispatch
    input  wire preg_t clear_preg,
    input  wire logic  wr_en,        // alu write-back
    input  wire preg_t wr_preg,
    input  wire word_t wr_value
);

    word_t               regs_q [NUM_PREG];
    logic [NUM_PREG-1:0] ready_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PREG; i++) begin
                regs_q[i]  <= '0;
                ready_q[i] <= (i < NUM_AREG);   // committed state is ready
            end
        end else begin
            // p0 is never written or cleared, so x0 reads zero
            if (wr_en && wr_preg != '0) begin
                regs_q[wr_preg]  <= wr_value;
                ready_q[wr_preg] <= 1'b1;
            end
            if (clear_en && clear_preg != '0) begin
                ready_q[clear_preg] <= 1'b0;
            end
        end
    end

    // no bypass, a dependent sees the ready bit one cycle after wb
    assign rd1_value = regs_q[rd1_preg];
    assign rd2_value = regs_q[rd2_preg];
    assign rd1_ready = ready_q[rd1_preg];
    assign rd2_ready = ready_q[rd2_preg];

endmodule

`default_nettype wire

// ==== rename_core.f ====
rename_pkg.sv
dispatch_unit.sv
map_table.sv
free_list.sv
issue_queue.sv
phys_regfile.sv
alu_unit.sv
reorder_buffer.sv
rename_core.sv
rename_core_checker.sv
rename_core_tb.sv

// ==== rename_core.sv ====
// rename core top level
`default_nettype none

module rename_core import rename_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    parameter int IQ_DEPTH  = 4
) (
    input  wire logic    clock,
    input  wire logic    rst_n,
    input  wire logic    inst_valid,
    input  wire alu_op_t inst_op,
    input  wire areg_t   inst_rd,
    input  wire areg_t   inst_rs1,
    input  wire areg_t   inst_rs2,
    input  wire word_t   inst_imm,
    output logic         stall,
    output logic         retire_valid,
    output areg_t        retire_rd,
    output word_t        retire_value
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    // dispatch strobes
    logic rename_en, fl_pop, iq_push, rob_alloc, clear_ready;
    preg_t dest_preg;

    // map lookups
    preg_t src1_preg, src2_preg, old_preg;

    // status back to dispatch
    preg_t            fl_free_preg;
    logic             fl_empty, rob_full, iq_full;
    logic [TAG_W-1:0] rob_tail;

    // issue
    logic             issue_valid;
    alu_op_t          issue_op;
    word_t            issue_imm;
    preg_t            issue_src1, issue_src2, issue_dest;
    logic [TAG_W-1:0] issue_tag;
    word_t            rd1_value, rd2_value;
    logic             rd1_ready, rd2_ready;

    // write-back and retire
    logic             wb_valid;
    preg_t            wb_preg;
    logic [TAG_W-1:0] wb_tag;
    word_t            wb_value;
    logic             free_en;
    preg_t            free_preg;

    //////////////////////////////////////////////////
    // rename
    //////////////////////////////////////////////////
    dispatch_unit dispatch_0 (
        .inst_valid (inst_valid),
        .inst_rd    (inst_rd),
        .fl_empty   (fl_empty),
        .free_preg  (fl_free_preg),
        .rob_full   (rob_full),
        .iq_full    (iq_full),
        .stall      (stall),
        .rename_en  (rename_en),     // -> map table
        .pop        (fl_pop),        // -> free list
        .iq_push    (iq_push),
        .rob_alloc  (rob_alloc),
        .clear_ready(clear_ready),   // -> regfile ready bit
        .dest_preg  (dest_preg)
    );

    map_table map_table_0 (
        .clock    (clock),
        .rst_n    (rst_n),
        .rename_en(rename_en),
        .rd       (inst_rd),
        .rs1      (inst_rs1),
        .rs2      (inst_rs2),
        .new_preg (dest_preg),
        .src1_preg(src1_preg),
        .src2_preg(src2_preg),
        .old_preg (old_preg)         // -> rob entry
    );

    free_list free_list_0 (
        .clock    (clock),
        .rst_n    (rst_n),
        .pop      (fl_pop),
        .push     (free_en),         // <- rob retire
        .push_preg(free_preg),
        .free_preg(fl_free_preg),
        .empty    (fl_empty)
    );

    //////////////////////////////////////////////////
    // issue and execute
    //////////////////////////////////////////////////
    issue_queue #(
        .IQ_DEPTH (IQ_DEPTH),
        .ROB_DEPTH(ROB_DEPTH)
    ) issue_queue_0 (
        .clock      (clock),
        .rst_n      (rst_n),
        .push       (iq_push),
        .op         (inst_op),
        .imm        (inst_imm),
        .src1_preg  (src1_preg),
        .src2_preg  (src2_preg),
        .dest_preg  (dest_preg),
        .rob_tag    (rob_tail),
        .src1_ready (rd1_ready),
        .src2_ready (rd2_ready),
        .full       (iq_full),
        .issue_valid(issue_valid),
        .issue_op   (issue_op),
        .issue_imm  (issue_imm),
        .issue_src1 (issue_src1),    // -> regfile port 1
        .issue_src2 (issue_src2),    // -> regfile port 2
        .issue_dest (issue_dest),
        .issue_tag  (issue_tag)
    );

    phys_regfile phys_regfile_0 (
        .clock     (clock),
        .rst_n     (rst_n),
        .rd1_preg  (issue_src1),
        .rd2_preg  (issue_src2),
        .rd1_value (rd1_value),
        .rd2_value (rd2_value),
        .rd1_ready (rd1_ready),
        .rd2_ready (rd2_ready),
        .clear_en  (clear_ready),
        .clear_preg(dest_preg),
        .wr_en     (wb_valid),
        .wr_preg   (wb_preg),
        .wr_value  (wb_value)
    );

    alu_unit #(
        .ROB_DEPTH(ROB_DEPTH)
    ) alu_0 (
        .clock      (clock),
        .rst_n      (rst_n),
        .issue_valid(issue_valid),
        .op         (issue_op),
        .imm        (issue_imm),
        .src1_value (rd1_value),
        .src2_value (rd2_value),
        .dest_preg  (issue_dest),
        .rob_tag    (issue_tag),
        .wb_valid   (wb_valid),
        .wb_preg    (wb_preg),
        .wb_tag     (wb_tag),
        .wb_value   (wb_value)
    );

    //////////////////////////////////////////////////
    // retire
    //////////////////////////////////////////////////
    reorder_buffer #(
        .ROB_DEPTH(ROB_DEPTH)
    ) rob_0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .alloc         (rob_alloc),
        .alloc_rd      (inst_rd),
        .alloc_old_preg(old_preg),
        .full          (rob_full),
        .tail_tag      (rob_tail),
        .wb_valid      (wb_valid),
        .wb_tag        (wb_tag),
        .wb_value      (wb_value),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_value  (retire_value),
        .free_en       (free_en),
        .free_preg     (free_preg)
    );

endmodule

`default_nettype wire

// ==== rename_core_checker.sv ====
// rename core assertions
`default_nettype none

module rename_core_checker import rename_pkg::*; (
    input wire logic  clock,
    input wire logic  rst_n,
    input wire logic  stall,
    input wire logic  retire_valid,
    input wire word_t retire_value,
    input wire logic  fl_pop,       // free list head taken
    input wire logic  fl_empty,
    input wire logic  rob_alloc,    // rob entry written
    input wire logic  rob_full
);

    //////////////////////////////////////////////////
    // reset behavior
    //////////////////////////////////////////////////
    reset_quiet: assert property (@(posedge clock) !rst_n |-> !retire_valid && !stall)
        else $error("retire_valid or stall high during reset");

    // nothing retires in the first cycle out of reset
    reset_exit: assert property (@(posedge clock) $rose(rst_n) |-> !retire_valid ##1 !retire_valid)
        else $error("retire_valid high in the first cycle after reset");

    //////////////////////////////////////////////////
    // retire and allocation rules
    //////////////////////////////////////////////////
    retire_known: assert property (@(posedge clock) disable iff (!rst_n)
        retire_valid |-> !$isunknown(retire_value))
        else $error("retire_value has unknown bits");

    pop_not_empty: assert property (@(posedge clock) disable iff (!rst_n)
        fl_pop |-> !fl_empty)    // dispatch must stall first
        else $error("free list popped while empty");

    alloc_not_full: assert property (@(posedge clock) disable iff (!rst_n)
        rob_alloc |-> !rob_full)
        else $error("rob written while full");

endmodule

`default_nettype wire

// ==== rename_core_tb.sv ====
// rename core testbench
`default_nettype none

module rename_core_tb import rename_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;     // after the rising edge
    localparam int N_RANDOM    = 100;

    logic    clock;
    logic    rst_n;
    logic    inst_valid;
    alu_op_t inst_op;
    areg_t   inst_rd;
    areg_t   inst_rs1;
    areg_t   inst_rs2;
    word_t   inst_imm;
    logic    stall;
    logic    retire_valid;
    areg_t   retire_rd;
    word_t   retire_value;

    // stimulus table
    alu_op_t tab_op  [$];
    areg_t   tab_rd  [$];
    areg_t   tab_rs1 [$];
    areg_t   tab_rs2 [$];
    word_t   tab_imm [$];

    word_t       model_regs [NUM_AREG];   // architectural reference state
    word_t       exp_value  [$];
    areg_t       exp_rd     [$];
    logic [31:0] lcg_state = 32'hb7f2;

    int   mismatch_count = 0;
    int   other_count    = 0;
    int   accepted_count = 0;
    int   retired_count  = 0;
    int   cycle_count    = 0;
    int   stall_cycles   = 0;            // seen behind the chain
    int   chain_end      = 0;            // first entry after the x11 chain
    int   directed_count = 0;
    logic table_ready    = 1'b0;

    rename_core #(
        .ROB_DEPTH(8),
        .IQ_DEPTH (4)
    ) dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst_op     (inst_op),
        .inst_rd     (inst_rd),
        .inst_rs1    (inst_rs1),
        .inst_rs2    (inst_rs2),
        .inst_imm    (inst_imm),
        .stall       (stall),
        .retire_valid(retire_valid),
        .retire_rd   (retire_rd),
        .retire_value(retire_value)
    );

    bind rename_core rename_core_checker checker_0 (
        .clock       (clock),
        .rst_n       (rst_n),
        .stall       (stall),
        .retire_valid(retire_valid),
        .retire_value(retire_value),
        .fl_pop      (fl_pop),
        .fl_empty    (fl_empty),
        .rob_alloc   (rob_alloc),
        .rob_full    (rob_full)
    );

    initial begin : clock_gen
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) cycle_count++;

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_areg(input string name, input areg_t actual, input areg_t expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model and stimulus
    //////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t model_result(input alu_op_t op, input word_t a, input word_t b,
                                           input word_t imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + imm;       // rs2 unused
            OP_SLL:  return a << b[4:0];
            default: return '0;
        endcase
    endfunction

    task automatic add_inst(input alu_op_t op, input areg_t rd, input areg_t rs1,
                            input areg_t rs2, input word_t imm);
        tab_op.push_back(op);
        tab_rd.push_back(rd);
        tab_rs1.push_back(rs1);
        tab_rs2.push_back(rs2);
        tab_imm.push_back(imm);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] r2;
        alu_op_t     op;
        add_inst(OP_ADDI, 5'd1, 5'd0, 5'd0, 32'd5);
        add_inst(OP_ADDI, 5'd2, 5'd0, 5'd0, 32'hffff_fffd);   // -3
        add_inst(OP_ADD,  5'd3, 5'd1, 5'd2, 32'd0);            // back to back
        add_inst(OP_SUB,  5'd4, 5'd1, 5'd2, 32'd0);
        add_inst(OP_AND,  5'd5, 5'd3, 5'd4, 32'd0);
        add_inst(OP_OR,   5'd6, 5'd3, 5'd4, 32'd0);
        add_inst(OP_XOR,  5'd7, 5'd6, 5'd2, 32'd0);
        add_inst(OP_ADDI, 5'd8, 5'd0, 5'd0, 32'd3);
        add_inst(OP_SLL,  5'd9, 5'd1, 5'd8, 32'd0);
        add_inst(OP_ADDI, 5'd0, 5'd9, 5'd0, 32'd100);          // x0 write, result still retired
        add_inst(OP_ADD,  5'd10, 5'd0, 5'd9, 32'd0);           // x0 must read zero
        add_inst(OP_SUB,  5'd0, 5'd10, 5'd1, 32'd0);
        // long chain on x11
        for (int k = 0; k < 6; k++) begin
            add_inst(OP_ADDI, 5'd11, 5'd11, 5'd0, 32'(k + 1));
        end
        chain_end = tab_op.size();
        // independent work queued behind the chain, raises stall
        add_inst(OP_ADDI, 5'd12, 5'd0, 5'd0, 32'h11);
        add_inst(OP_ADDI, 5'd13, 5'd0, 5'd0, 32'hdead_0000);
        add_inst(OP_ADD,  5'd14, 5'd1, 5'd2, 32'd0);
        add_inst(OP_XOR,  5'd15, 5'd9, 5'd8, 32'd0);
        add_inst(OP_OR,   5'd16, 5'd1, 5'd8, 32'd0);
        add_inst(OP_ADD,  5'd17, 5'd11, 5'd10, 32'd0);
        directed_count = tab_op.size();
        // random part, renames far more than 32 destinations
        for (int n = 0; n < N_RANDOM; n++) begin
            lcg_state = lcg_next(lcg_state);
            r         = lcg_state;
            lcg_state = lcg_next(lcg_state);
            r2        = lcg_state;
            op = (r[31:29] == 3'd7) ? OP_ADDI : alu_op_t'(r[31:29]);
            add_inst(op, r[28:24], r[23:19], r[18:14], r2);
        end
    endtask

    // sequential semantics at the moment of acceptance
    task automatic accept_inst(input int idx);
        word_t result;
        result = model_result(tab_op[idx], model_regs[tab_rs1[idx]],
                              model_regs[tab_rs2[idx]], tab_imm[idx]);
        exp_value.push_back(result);
        exp_rd.push_back(tab_rd[idx]);
        if (tab_rd[idx] != '0) model_regs[tab_rd[idx]] = result;   // x0 stays zero
        accepted_count++;
    endtask

    //////////////////////////////////////////////////
    // retire monitor, sampled mid cycle
    //////////////////////////////////////////////////
    always @(negedge clock) begin
        if (rst_n && retire_valid) begin
            if (exp_value.size() == 0) begin
                other_count++;
                $display("ERROR at %0t: retirement with no accepted instruction outstanding",
                         $time);
            end else begin
                check_areg("retire_rd", retire_rd, exp_rd.pop_front());
                check_word("retire_value", retire_value, exp_value.pop_front());
            end
            retired_count++;
        end
    end

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = 10 * tab_op.size() + 50;
        while (cycle_count < limit) @(posedge clock);
        $display("ERROR: timeout after %0d cycles, %0d of %0d instructions retired",
                 cycle_count, retired_count, tab_op.size());
        $display("Simulation failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin : main
        logic accepted;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst_op    = OP_ADD;
        inst_rd    = '0;
        inst_rs1   = '0;
        inst_rs2   = '0;
        inst_imm   = '0;
        for (int i = 0; i < NUM_AREG; i++) model_regs[i] = '0;
        build_table();
        table_ready = 1'b1;

        // two reset cycles, then the first cycle out of reset
        repeat (2) begin
            @(negedge clock);
            check_flag("stall", stall, 1'b0);
            check_flag("retire_valid", retire_valid, 1'b0);
        end
        @(posedge clock);
        #(DRIVE_DELAY) rst_n = 1'b1;
        @(negedge clock);
        check_flag("stall", stall, 1'b0);
        check_flag("retire_valid", retire_valid, 1'b0);
        @(posedge clock);
        #(DRIVE_DELAY);

        for (int idx = 0; idx < tab_op.size(); idx++) begin
            inst_valid = 1'b1;
            inst_op    = tab_op[idx];
            inst_rd    = tab_rd[idx];
            inst_rs1   = tab_rs1[idx];
            inst_rs2   = tab_rs2[idx];
            inst_imm   = tab_imm[idx];
            accepted   = 1'b0;
            while (!accepted) begin
                @(negedge clock);            // stall settled, inputs held
                if (!stall) begin
                    accepted = 1'b1;
                    accept_inst(idx);
                end else if (idx >= chain_end && idx < directed_count) begin
                    stall_cycles++;
                end
                @(posedge clock);
                #(DRIVE_DELAY);
            end
        end
        inst_valid = 1'b0;

        if (stall_cycles == 0) begin
            other_count++;
            $display("ERROR: stall never rose behind the dependency chain");
        end

        while (retired_count < accepted_count) @(posedge clock);
        repeat (5) @(posedge clock);         // catch stray retirements
        if (retired_count != accepted_count || exp_value.size() != 0) begin
            other_count++;
            $display("ERROR: %0d instructions accepted but %0d retired",
                     accepted_count, retired_count);
        end

        $display("errors: %0d mismatches, %0d other (%0d accepted, %0d retired)",
                 mismatch_count, other_count, accepted_count, retired_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rename_pkg.sv ====
// rename core shared types
`default_nettype none

package rename_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int XLEN     = 32;   // data path
    localparam int NUM_AREG = 32;   // x0..x31
    localparam int NUM_PREG = 64;   // 32 committed + 32 in the free pool

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_AREG)-1:0] areg_t;
    typedef logic [$clog2(NUM_PREG)-1:0] preg_t;

    //////////////////////////////////////////////////
    // alu opcodes
    //////////////////////////////////////////////////
    typedef logic [2:0] alu_op_t;

    localparam alu_op_t OP_ADD  = 3'd0;
    localparam alu_op_t OP_SUB  = 3'd1;
    localparam alu_op_t OP_AND  = 3'd2;
    localparam alu_op_t OP_OR   = 3'd3;
    localparam alu_op_t OP_XOR  = 3'd4;
    localparam alu_op_t OP_ADDI = 3'd5;   // second operand is the immediate
    localparam alu_op_t OP_SLL  = 3'd6;   // shift by rs2[4:0]

endpackage

`default_nettype wire

// ==== reorder_buffer.sv ====
// reorder buffer with in-order retire
`default_nettype none

module reorder_buffer import rename_pkg::*; #(
    parameter int ROB_DEPTH = 8   // power of two
) (
    input  wire logic                         clock,
    input  wire logic                         rst_n,
    // allocation at dispatch
    input  wire logic                         alloc,
    input  wire areg_t                        alloc_rd,
    input  wire preg_t                        alloc_old_preg,
    output logic                              full,
    output logic [$clog2(ROB_DEPTH)-1:0]      tail_tag,
    // completion
    input  wire logic                         wb_valid,
    input  wire logic [$clog2(ROB_DEPTH)-1:0] wb_tag,
    input  wire word_t                        wb_value,
    // retire
    output logic                              retire_valid,
    output areg_t                             retire_rd,
    output word_t                             retire_value,
    output logic                              free_en,
    output preg_t                             free_preg
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    areg_t                rd_q    [ROB_DEPTH];
    preg_t                old_q   [ROB_DEPTH];
    word_t                value_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;

    logic [TAG_W-1:0] head_q;
    logic [TAG_W-1:0] tail_q;
    logic [TAG_W:0]   count_q;
    logic             retire_go;   // head is done

    assign full      = (count_q == (TAG_W + 1)'(ROB_DEPTH));
    assign tail_tag  = tail_q;
    assign retire_go = (count_q != '0) & done_q[head_q];

    ////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            done_q       <= '0;
            retire_valid <= 1'b0;
            free_en      <= 1'b0;
        end else begin
            if (alloc) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (wb_valid) done_q[wb_tag] <= 1'b1;   // never the entry at tail
            if (retire_go) head_q <= head_q + 1'b1;
            case ({alloc, retire_go})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            retire_valid <= retire_go;
            free_en      <= retire_go & (old_q[head_q] != '0);   // p0 stays out
        end
    end

    ////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (alloc) begin
            rd_q[tail_q]  <= alloc_rd;
            old_q[tail_q] <= alloc_old_preg;
        end
        if (wb_valid) value_q[wb_tag] <= wb_value;
        if (retire_go) begin
            retire_rd    <= rd_q[head_q];
            retire_value <= value_q[head_q];
            free_preg    <= old_q[head_q];      // old mapping back to the pool
        end
    end

endmodule

`default_nettype wire
